//--- project.f
+incdir+design
design/io_pkg.sv
design/bus_reg_file.sv
design/gpio_input_monitor.sv
design/key_debounce.sv
design/hps_reset_seq.sv
design/io_top.sv
verification/tb_io_top.sv

//--- verification/io_stimulus.txt
# columns: command, arg a, arg b (hex). W addr data, R addr expect, P pin_hi pin_lo,
# K keys_n, N cycles, O/E hi lo, J irq req, I level limit, X req limit, Q cycles
E 0 00000000
O 0 00000000
J 0 0
R 0 00000000
R 1 00000000
R 2 00000000
R 3 00000000
R 6 00000000
R 7 00000000
R 8 00000000
W 0 12345678
W 1 fffffffa
W 2 cafef00d
W 3 00000003
W 6 5a5a5a5a
R 0 12345678
R 1 0000000a
R 2 cafef00d
R 3 00000003
R 6 5a5a5a5a
O a 12345678
E 3 cafef00d
R 9 00000000
R f 00000000
W 6 00000000
P 5 a5a5a5a5
N 4 0
R 4 a5a5a5a5
R 5 00000005
R 7 00000000
W 6 0000000f
P 5 a5a5a5a4
I 1 14
R 7 00000001
W 7 00000001
I 0 14
R 7 00000000
P 5 a5a5a4a4
N 8 0
J 0 0
R 7 00000000
K 2 0
N a 0
K 3 0
N 28 0
R 8 00000000
J 0 0
K 2 0
X 2 64
R 8 00000001
Q 28 0
K 3 0
N 28 0
K 1 0
X 1 64
K 3 0
N 28 0
K 0 0
X 4 64
Q 1e 0
K 3 0
N 28 0
R 8 00000000

//--- verification/tb_io_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "io_macros.svh"

module tb_io_top;

	import io_pkg::*;

	localparam int TB_DEBOUNCE = 20;  // short debounce for simulation

	logic                      clk;
	logic                      arst_n;
	bus_req_t                  bus_req;
	bus_rsp_t                  bus_rsp;
	logic [`IO_GPIO_WIDTH-1:0] pin_in;
	logic [`IO_GPIO_WIDTH-1:0] pin_out;
	logic [`IO_GPIO_WIDTH-1:0] pin_oe;
	logic [`IO_KEY_WIDTH-1:0]  keys_n;
	logic                      irq;
	reset_req_t                reset_req;

	integer          fd;
	integer          code;
	logic [7:0]      cmd;       // one letter per stimulus line
	logic [31:0]     arg_a;
	logic [31:0]     arg_b;
	logic [8*128-1:0] line_buf; // rest of a comment line
	bit              done;

	io_top #(
		.DEBOUNCE_CYCLES (TB_DEBOUNCE)
	) dut0 (
		.clk       (clk),
		.arst_n    (arst_n),
		.bus_req   (bus_req),
		.pin_in    (pin_in),
		.keys_n    (keys_n),
		.bus_rsp   (bus_rsp),
		.pin_out   (pin_out),
		.pin_oe    (pin_oe),
		.irq       (irq),
		.reset_req (reset_req)
	);

	always #4 clk = ~clk;  // 8 ns period

	// ========================================
	// helpers
	// ========================================
	task automatic abort_run(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("FAIL at %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
			abort_run("value mismatch");
		end
	endtask

	// next edge, then settle 1 ns before driving or sampling
	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic bus_write(input logic [3:0] addr, input logic [31:0] data);
		bus_req.wr    = 1'b1;
		bus_req.addr  = addr;
		bus_req.wdata = data;
		step();  // taken at this edge
		bus_req.wr    = 1'b0;
		bus_req.wdata = '0;
	endtask

	task automatic bus_read(input logic [3:0] addr, input logic [31:0] expected);
		check_value(bus_rsp.valid, 1'b0, "valid high before rd");
		bus_req.rd   = 1'b1;
		bus_req.addr = addr;
		step();
		bus_req.rd   = 1'b0;
		check_value(bus_rsp.valid, 1'b1, "valid one cycle after rd");
		check_value(bus_rsp.rdata, expected, $sformatf("read data at address %0h", addr));
		step();
		check_value(bus_rsp.valid, 1'b0, "valid longer than one cycle");
	endtask

	task automatic wait_irq(input logic level, input int limit);
		int n;
		n = 0;
		while (irq !== level) begin
			if (n >= limit)
				abort_run($sformatf("irq did not reach %0d within %0d cycles", level, limit));
			step();
			n++;
		end
	endtask

	task automatic wait_reset_pulse(input logic [2:0] kind, input int limit);
		int n;
		int width;
		n = 0;
		while (reset_req == '0) begin
			if (n >= limit)
				abort_run($sformatf("no reset request pulse within %0d cycles", limit));
			step();
			n++;
		end
		check_value(reset_req, kind, "reset request kind");
		width = 0;
		while (reset_req != '0) begin  // count the high cycles
			if (width > 4 * `IO_RST_PULSE_CYCLES)
				abort_run("reset request pulse never ended");
			step();
			width++;
		end
		check_value(width, `IO_RST_PULSE_CYCLES, "reset request pulse width");
	endtask

	task automatic expect_quiet(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			check_value(reset_req, 3'b000, "reset request while keys held");
			step();
		end
	endtask

	task automatic run_command(input logic [7:0] c, input logic [31:0] a, input logic [31:0] b);
		case (c)
			"W": bus_write(a[3:0], b);
			"R": bus_read(a[3:0], b);
			"P": pin_in = {a[3:0], b};  // hi nibble, low word
			"K": keys_n = a[1:0];       // raw, low = pressed
			"N": repeat (a) step();
			"O": check_value(pin_out, {a[3:0], b}, "pin_out");
			"E": check_value(pin_oe, {a[3:0], b}, "pin_oe");
			"J": begin
				check_value(irq, a[0], "irq level");
				check_value(reset_req, b[2:0], "reset request level");
			end
			"I": wait_irq(a[0], b);
			"X": wait_reset_pulse(a[2:0], b);
			"Q": expect_quiet(a);
			default: abort_run($sformatf("unknown stimulus command %c", c));
		endcase
	endtask

	// ========================================
	// main sequence
	// ========================================
	initial begin
		clk     = 1'b0;
		arst_n  = 1'b0;
		bus_req = '0;
		pin_in  = '0;
		keys_n  = '1;  // released
		done    = 1'b0;

		fd = $fopen("verification/io_stimulus.txt", "r");
		if (fd == 0)
			abort_run("cannot open verification/io_stimulus.txt");

		repeat (16) @(posedge clk);
		#1;
		arst_n = 1'b1;
		step();

		while (!done) begin
			code = $fscanf(fd, " %c", cmd);
			if (code != 1) begin
				done = 1'b1;  // end of file
			end else if (cmd == "#") begin
				code = $fgets(line_buf, fd);
			end else begin
				code = $fscanf(fd, "%h %h", arg_a, arg_b);
				if (code != 2)
					abort_run("malformed line in stimulus file");
				run_command(cmd, arg_a, arg_b);
			end
		end
		$fclose(fd);

		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- design/io_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "io_macros.svh"

module io_top #(
	parameter int DEBOUNCE_CYCLES = `IO_DEBOUNCE_CYCLES
) (
	input  wire logic                      clk,
	input  wire logic                      arst_n,
	input  wire io_pkg::bus_req_t          bus_req,
	input  wire logic [`IO_GPIO_WIDTH-1:0] pin_in,
	input  wire logic [`IO_KEY_WIDTH-1:0]  keys_n,   // raw buttons, low = pressed
	output io_pkg::bus_rsp_t               bus_rsp,
	output logic [`IO_GPIO_WIDTH-1:0]      pin_out,
	output logic [`IO_GPIO_WIDTH-1:0]      pin_oe,
	output logic                           irq,      // arduino pin in the board top
	output io_pkg::reset_req_t             reset_req
);

	logic [`IO_GPIO_WIDTH-1:0] pin_sync;
	logic [`IO_BUS_WIDTH-1:0]  irq_mask;
	logic [`IO_BUS_WIDTH-1:0]  irq_status;
	logic [`IO_BUS_WIDTH-1:0]  irq_clear;
	logic [`IO_KEY_WIDTH-1:0]  keys_db_n;

	// host side register map
	bus_reg_file u_regs (
		.clk        (clk),
		.arst_n     (arst_n),
		.bus_req    (bus_req),
		.pin_sync   (pin_sync),
		.irq_status (irq_status),
		.keys_db_n  (keys_db_n),
		.bus_rsp    (bus_rsp),
		.pin_out    (pin_out),
		.pin_oe     (pin_oe),
		.irq_mask   (irq_mask),
		.irq_clear  (irq_clear)
	);

	gpio_input_monitor u_gpio_in (
		.clk        (clk),
		.arst_n     (arst_n),
		.pin_in     (pin_in),
		.irq_mask   (irq_mask),
		.irq_clear  (irq_clear),
		.pin_sync   (pin_sync),
		.irq_status (irq_status),
		.irq        (irq)
	);

	key_debounce #(
		.KEY_WIDTH     (`IO_KEY_WIDTH),
		.STABLE_CYCLES (DEBOUNCE_CYCLES)
	) u_debounce (
		.clk       (clk),
		.arst_n    (arst_n),
		.keys_n    (keys_n),
		.keys_db_n (keys_db_n)
	);

	hps_reset_seq u_rst_seq (
		.clk       (clk),
		.arst_n    (arst_n),
		.keys_db_n (keys_db_n),
		.reset_req (reset_req)
	);

endmodule

`default_nettype wire

//--- design/hps_reset_seq.sv
`default_nettype none
`timescale 1ns/1ps

`include "io_macros.svh"

module hps_reset_seq (
	input  wire logic                     clk,
	input  wire logic                     arst_n,
	input  wire logic [`IO_KEY_WIDTH-1:0] keys_db_n,
	output io_pkg::reset_req_t            reset_req
);

	import io_pkg::*;

	localparam int PULSE_W = $clog2(`IO_RST_PULSE_CYCLES + 1);

	rst_state_e               state;
	logic [PULSE_W-1:0]       pulse_cnt;
	logic [`IO_KEY_WIDTH-1:0] pressed;

	assign pressed = ~keys_db_n;

	// ========================================
	// request FSM
	// ========================================
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= IDLE;
			pulse_cnt <= '0;
			reset_req <= '0;
		end else begin
			case (state)
				IDLE: begin
					// all keys are up here, so any press is a new one
					if (|pressed) begin
						reset_req.cold  <= pressed[0] & pressed[1];
						reset_req.warm  <= pressed[0] & ~pressed[1];
						reset_req.debug <= pressed[1] & ~pressed[0];
						pulse_cnt       <= '0;
						state           <= PULSE;
					end
				end
				PULSE: begin
					if (pulse_cnt == PULSE_W'(`IO_RST_PULSE_CYCLES - 1)) begin
						reset_req <= '0;
						state     <= WAIT_RELEASE;
					end else begin
						pulse_cnt <= pulse_cnt + 1'b1;
					end
				end
				WAIT_RELEASE: begin
					if (!(|pressed))
						state <= IDLE;  // no repeat while held
				end
				default: state <= IDLE;
			endcase
		end
	end

	a_req_onehot: assert property (@(posedge clk) disable iff (!arst_n)
		$onehot0(reset_req));

endmodule

`default_nettype wire

//--- design/key_debounce.sv
`default_nettype none
`timescale 1ns/1ps

`include "io_macros.svh"

module key_debounce #(
	parameter int KEY_WIDTH     = `IO_KEY_WIDTH,
	parameter int STABLE_CYCLES = `IO_DEBOUNCE_CYCLES
) (
	input  wire logic                 clk,
	input  wire logic                 arst_n,
	input  wire logic [KEY_WIDTH-1:0] keys_n,     // raw, asynchronous
	output logic [KEY_WIDTH-1:0]      keys_db_n   // debounced, low = pressed
);

	localparam int CNT_W = $clog2(STABLE_CYCLES + 1);

	logic [`IO_SYNC_STAGES-1:0][KEY_WIDTH-1:0] key_sync;
	logic [KEY_WIDTH-1:0]                      key_raw;
	logic [KEY_WIDTH-1:0][CNT_W-1:0]           cnt;       // one per key

	// buttons are async to clk, sync before counting
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			key_sync <= '1;  // released
		end else begin
			key_sync[0] <= keys_n;
			for (int s = 1; s < `IO_SYNC_STAGES; s++)
				key_sync[s] <= key_sync[s-1];
		end
	end

	assign key_raw = key_sync[`IO_SYNC_STAGES-1];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cnt       <= '0;
			keys_db_n <= '1;
		end else begin
			for (int i = 0; i < KEY_WIDTH; i++) begin
				if (key_raw[i] == keys_db_n[i]) begin
					cnt[i] <= '0;  // bounce back, start over
				end else if (cnt[i] == CNT_W'(STABLE_CYCLES - 1)) begin
					keys_db_n[i] <= key_raw[i];  // stable long enough
					cnt[i]       <= '0;
				end else begin
					cnt[i] <= cnt[i] + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- design/gpio_input_monitor.sv
`default_nettype none
`timescale 1ns/1ps

`include "io_macros.svh"

module gpio_input_monitor (
	input  wire logic                      clk,
	input  wire logic                      arst_n,
	input  wire logic [`IO_GPIO_WIDTH-1:0] pin_in,
	input  wire logic [`IO_BUS_WIDTH-1:0]  irq_mask,
	input  wire logic [`IO_BUS_WIDTH-1:0]  irq_clear,
	output logic [`IO_GPIO_WIDTH-1:0]      pin_sync,
	output logic [`IO_BUS_WIDTH-1:0]       irq_status,
	output logic                           irq
);

	logic [`IO_SYNC_STAGES-1:0][`IO_GPIO_WIDTH-1:0] sync_q;  // [0] sees the raw pins
	logic [`IO_BUS_WIDTH-1:0]                       prev_lo;
	logic [`IO_BUS_WIDTH-1:0]                       change;

	// ========================================
	// synchronizer
	// ========================================
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sync_q <= '0;
		end else begin
			sync_q[0] <= pin_in;
			for (int s = 1; s < `IO_SYNC_STAGES; s++)
				sync_q[s] <= sync_q[s-1];
		end
	end

	assign pin_sync = sync_q[`IO_SYNC_STAGES-1];

	// ========================================
	// change detect and sticky status
	// ========================================
	assign change = (pin_sync[`IO_BUS_WIDTH-1:0] ^ prev_lo) & irq_mask;  // either edge

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			prev_lo    <= '0;
			irq_status <= '0;
			irq        <= 1'b0;
		end else begin
			prev_lo    <= pin_sync[`IO_BUS_WIDTH-1:0];
			irq_status <= (irq_status & ~irq_clear) | change;  // new change beats clear
			irq        <= |irq_status;
		end
	end

	// a status bit only rises where its mask bit was set
	a_status_masked: assert property (@(posedge clk) disable iff (!arst_n)
		(irq_status & ~$past(irq_status) & ~$past(irq_mask)) == '0);

endmodule

`default_nettype wire

//--- design/bus_reg_file.sv
`default_nettype none
`timescale 1ns/1ps

`include "io_macros.svh"

module bus_reg_file (
	input  wire logic                      clk,
	input  wire logic                      arst_n,
	input  wire io_pkg::bus_req_t          bus_req,
	input  wire logic [`IO_GPIO_WIDTH-1:0] pin_sync,
	input  wire logic [`IO_BUS_WIDTH-1:0]  irq_status,
	input  wire logic [`IO_KEY_WIDTH-1:0]  keys_db_n,
	output io_pkg::bus_rsp_t               bus_rsp,
	output logic [`IO_GPIO_WIDTH-1:0]      pin_out,
	output logic [`IO_GPIO_WIDTH-1:0]      pin_oe,
	output logic [`IO_BUS_WIDTH-1:0]       irq_mask,
	output logic [`IO_BUS_WIDTH-1:0]       irq_clear
);

	import io_pkg::*;

	localparam int HI_WIDTH = `IO_GPIO_WIDTH - `IO_BUS_WIDTH;  // pins 35:32

	reg_addr_e                req_addr;
	logic [`IO_BUS_WIDTH-1:0] out_lo;
	logic [HI_WIDTH-1:0]      out_hi;
	logic [`IO_BUS_WIDTH-1:0] ddr_lo;
	logic [HI_WIDTH-1:0]      ddr_hi;
	logic [`IO_BUS_WIDTH-1:0] rd_mux;
	logic                     rsp_valid;
	logic [`IO_BUS_WIDTH-1:0] rsp_rdata;

	assign req_addr = reg_addr_e'(bus_req.addr);

	// ========================================
	// write side
	// ========================================
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_lo   <= '0;
			out_hi   <= '0;
			ddr_lo   <= '0;  // all pins start as inputs
			ddr_hi   <= '0;
			irq_mask <= '0;
		end else if (bus_req.wr) begin
			case (req_addr)
				OUT_LO:   out_lo   <= bus_req.wdata;
				OUT_HI:   out_hi   <= bus_req.wdata[HI_WIDTH-1:0];
				DDR_LO:   ddr_lo   <= bus_req.wdata;
				DDR_HI:   ddr_hi   <= bus_req.wdata[HI_WIDTH-1:0];
				IRQ_MASK: irq_mask <= bus_req.wdata;
				default: ;  // read only or unmapped
			endcase
		end
	end

	// write-1-to-clear, acts on the same edge as the write
	assign irq_clear = (bus_req.wr && req_addr == IRQ_STATUS) ? bus_req.wdata : '0;

	assign pin_out = {out_hi, out_lo};
	assign pin_oe  = {ddr_hi, ddr_lo};

	// ========================================
	// read side
	// ========================================
	always_comb begin
		rd_mux = '0;  // unmapped and upper bits read zero
		case (req_addr)
			OUT_LO:     rd_mux = out_lo;
			OUT_HI:     rd_mux[HI_WIDTH-1:0] = out_hi;
			DDR_LO:     rd_mux = ddr_lo;
			DDR_HI:     rd_mux[HI_WIDTH-1:0] = ddr_hi;
			IN_LO:      rd_mux = pin_sync[`IO_BUS_WIDTH-1:0];
			IN_HI:      rd_mux[HI_WIDTH-1:0] = pin_sync[`IO_GPIO_WIDTH-1:`IO_BUS_WIDTH];
			IRQ_MASK:   rd_mux = irq_mask;
			IRQ_STATUS: rd_mux = irq_status;
			KEYS:       rd_mux[`IO_KEY_WIDTH-1:0] = ~keys_db_n;  // pressed reads 1
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			rsp_valid <= 1'b0;
		else
			rsp_valid <= bus_req.rd;
	end

	always_ff @(posedge clk) begin
		if (bus_req.rd)
			rsp_rdata <= rd_mux;  // held until the next read
	end

	assign bus_rsp = '{valid: rsp_valid, rdata: rsp_rdata};

	// host never issues read and write together
	a_rd_wr_excl: assert property (@(posedge clk) disable iff (!arst_n)
		!(bus_req.rd && bus_req.wr));

endmodule

`default_nettype wire

//--- design/io_pkg.sv
`default_nettype none

`include "io_macros.svh"

package io_pkg;

	// ========================================
	// host bus
	// ========================================
	typedef struct packed {
		logic                      wr;    // write strobe, never stalls
		logic                      rd;    // read strobe
		logic [`IO_ADDR_WIDTH-1:0] addr;  // word address
		logic [`IO_BUS_WIDTH-1:0]  wdata;
	} bus_req_t;

	typedef struct packed {
		logic                     valid;  // one cycle after rd
		logic [`IO_BUS_WIDTH-1:0] rdata;
	} bus_rsp_t;

	// requests towards the hps, active high
	typedef struct packed {
		logic cold;
		logic warm;
		logic debug;
	} reset_req_t;

	// register map, word addresses
	typedef enum logic [`IO_ADDR_WIDTH-1:0] {
		OUT_LO     = 4'd0,  // output values, pins 31:0
		OUT_HI     = 4'd1,  // output values, pins 35:32
		DDR_LO     = 4'd2,  // direction, 1 drives the pin
		DDR_HI     = 4'd3,
		IN_LO      = 4'd4,  // synchronized readback
		IN_HI      = 4'd5,
		IRQ_MASK   = 4'd6,
		IRQ_STATUS = 4'd7,  // sticky, write 1 to clear
		KEYS       = 4'd8   // debounced keys, 1 = pressed
	} reg_addr_e;

	typedef enum logic [1:0] {
		IDLE,
		PULSE,
		WAIT_RELEASE
	} rst_state_e;

endpackage

`default_nettype wire

//--- design/io_macros.svh
`ifndef IO_MACROS_SVH
`define IO_MACROS_SVH

// ========================================
// widths
// ========================================
`define IO_GPIO_WIDTH 36        // header pins on one gpio connector
`define IO_BUS_WIDTH 32         // host data bus
`define IO_ADDR_WIDTH 4         // word address, 16 slots
`define IO_KEY_WIDTH 2          // push buttons

// ========================================
// timing
// ========================================
`define IO_SYNC_STAGES 2        // flops in each input synchronizer
`define IO_DEBOUNCE_CYCLES 50000 // 1 ms at 50 MHz
`define IO_RST_PULSE_CYCLES 8   // width of one hps reset request

`endif
